// ==== design/panel_pkg.sv ====
package panel_pkg;

	// cycles a level must hold before the debouncer takes it
	// kept small for simulation
	localparam int stable_ticks = 4;

	// count word width
	localparam int cnt_width = 8;

	// top of the bcd range, 99
	localparam logic [cnt_width - 1 : 0] bcd_max = 8'h99;

	// one command per cycle from decode to execute
	typedef enum logic [2:0] {
		cmd_none,
		cmd_up,
		cmd_down,
		cmd_clear,
		cmd_mode
	} t_cmd;

	// two bcd digits, tens then ones
	typedef struct packed {
		logic [3:0] hi;
		logic [3:0] lo;
	} t_bcd_digits;

	// one count word, read as a byte or as two digits
	typedef union packed {
		logic [cnt_width - 1 : 0] raw;
		t_bcd_digits bcd;
	} t_count_word;

	// hex digit to segments, active high, bit 6 = g ... bit 0 = a
	localparam logic [0:15][6:0] seg_table = '{
		7'h3f, 7'h06, 7'h5b, 7'h4f,
		7'h66, 7'h6d, 7'h7d, 7'h07,
		7'h7f, 7'h6f, 7'h77, 7'h7c,
		7'h39, 7'h5e, 7'h79, 7'h71
	};

endpackage

// ==== design/count_if.sv ====
`timescale 1ns/1ps

interface count_if;
	import panel_pkg::*;

	// count word, both readings
	t_count_word count;
	// level, high in bcd mode
	logic bcd_mode;
	// one cycle, a step ran past the range end
	logic wrapped;
	// one cycle, count was cleared by command or mode change
	logic cleared;

	// execute side
	modport exec_mp(output count, output bcd_mode, output wrapped, output cleared);

	// result side
	modport res_mp(input count, input bcd_mode, input wrapped, input cleared);

endinterface

// ==== design/debounce_button.sv ====
`timescale 1ns/1ps

module debounce_button (
	input logic in_clk,
	input logic in_rst,
	input logic raw,
	output logic pulse,
	output logic toggled
);
	import panel_pkg::*;

	// counter must reach stable_ticks
	localparam int stable_w = $clog2(stable_ticks + 1);

	// button states
	typedef enum logic [1:0] {
		st_not_pressed,
		st_pressed,
		st_released
	} t_btn_state;

	t_btn_state state, state_next;
	logic [stable_w - 1 : 0] stable_cnt, stable_cnt_next;
	logic pulse_next;
	logic toggled_next;

	always_ff @(posedge in_clk, posedge in_rst) begin
		if (in_rst) begin
			state <= st_not_pressed;
			stable_cnt <= '0;
			pulse <= 1'b0;
			toggled <= 1'b0;
		end else begin
			state <= state_next;
			stable_cnt <= stable_cnt_next;
			pulse <= pulse_next;
			toggled <= toggled_next;
		end
	end

	always_comb begin
		// hold by default, pulse only for one cycle
		state_next = state;
		stable_cnt_next = stable_cnt;
		pulse_next = 1'b0;
		toggled_next = toggled;

		case (state)
			st_not_pressed: begin
				// wait for a steady high
				if (!raw) begin
					stable_cnt_next = '0;
				end else if (stable_cnt == stable_w'(stable_ticks)) begin
					stable_cnt_next = '0;
					state_next = st_pressed;
				end else begin
					stable_cnt_next = stable_cnt + 1'b1;
				end
			end
			st_pressed: begin
				// wait for a steady low
				if (raw) begin
					stable_cnt_next = '0;
				end else if (stable_cnt == stable_w'(stable_ticks)) begin
					stable_cnt_next = '0;
					state_next = st_released;
				end else begin
					stable_cnt_next = stable_cnt + 1'b1;
				end
			end
			st_released: begin
				// full press seen, fire and flip
				stable_cnt_next = '0;
				state_next = st_not_pressed;
				pulse_next = 1'b1;
				toggled_next = ~toggled;
			end
			default: begin
				state_next = st_not_pressed;
				stable_cnt_next = '0;
			end
		endcase
	end

endmodule

// ==== design/btn_decode.sv ====
`timescale 1ns/1ps

module btn_decode (
	input logic in_clk,
	input logic in_rst,
	input logic up_pulse,
	input logic down_pulse,
	input logic clear_pulse,
	output panel_pkg::t_cmd cmd
);
	import panel_pkg::*;

	t_cmd cmd_next;

	// fixed priority
	// clear first, then up, then down
	always_comb begin
		if (clear_pulse) begin
			cmd_next = cmd_clear;
		end else if (up_pulse) begin
			cmd_next = cmd_up;
		end else if (down_pulse) begin
			cmd_next = cmd_down;
		end else begin
			cmd_next = cmd_none;
		end
	end

	// one-cycle strobe, cmd_none when idle
	always_ff @(posedge in_clk, posedge in_rst) begin
		if (in_rst) begin
			cmd <= cmd_none;
		end else begin
			cmd <= cmd_next;
		end
	end

	// mode button not handled here
	// execute follows its toggle level

endmodule

// ==== design/count_exec.sv ====
`timescale 1ns/1ps

module count_exec (
	input logic in_clk,
	input logic in_rst,
	input panel_pkg::t_cmd cmd,
	input logic mode_level,
	count_if.exec_mp cnt
);
	import panel_pkg::*;

	t_count_word count_q, count_next;
	logic bcd_q;
	logic wrapped_q, wrapped_next;
	logic cleared_q, cleared_next;
	logic mode_change;

	// toggle level moved away from the held mode
	assign mode_change = (mode_level != bcd_q);

	always_comb begin
		count_next = count_q;
		wrapped_next = 1'b0;
		cleared_next = 1'b0;

		if (mode_change || cmd == cmd_clear) begin
			// mode change or clear, back to zero
			count_next.raw = '0;
			cleared_next = 1'b1;
		end else if (cmd == cmd_up) begin
			if (!bcd_q) begin
				// plain byte, modulo 256
				count_next.raw = count_q.raw + 1'b1;
				wrapped_next = (count_q.raw == '1);
			end else if (count_q.raw == bcd_max) begin
				// 99 rolls to 00
				count_next.raw = '0;
				wrapped_next = 1'b1;
			end else if (count_q.bcd.lo == 4'd9) begin
				// carry into tens
				count_next.bcd.lo = 4'd0;
				count_next.bcd.hi = count_q.bcd.hi + 1'b1;
			end else begin
				count_next.bcd.lo = count_q.bcd.lo + 1'b1;
			end
		end else if (cmd == cmd_down) begin
			if (!bcd_q) begin
				count_next.raw = count_q.raw - 1'b1;
				wrapped_next = (count_q.raw == '0);
			end else if (count_q.raw == '0) begin
				// 00 rolls to 99
				count_next.raw = bcd_max;
				wrapped_next = 1'b1;
			end else if (count_q.bcd.lo == 4'd0) begin
				// borrow from tens
				count_next.bcd.lo = 4'd9;
				count_next.bcd.hi = count_q.bcd.hi - 1'b1;
			end else begin
				count_next.bcd.lo = count_q.bcd.lo - 1'b1;
			end
		end
	end

	always_ff @(posedge in_clk, posedge in_rst) begin
		if (in_rst) begin
			count_q <= '0;
			bcd_q <= 1'b0;
			wrapped_q <= 1'b0;
			cleared_q <= 1'b0;
		end else begin
			count_q <= count_next;
			// follow the mode toggle
			bcd_q <= mode_level;
			wrapped_q <= wrapped_next;
			cleared_q <= cleared_next;
		end
	end

	// out to result stage
	assign cnt.count = count_q;
	assign cnt.bcd_mode = bcd_q;
	assign cnt.wrapped = wrapped_q;
	assign cnt.cleared = cleared_q;

endmodule

// ==== design/seg_result.sv ====
`timescale 1ns/1ps

module seg_result (
	input logic in_clk,
	input logic in_rst,
	count_if.res_mp cnt,
	output logic [6:0] seg_hi,
	output logic [6:0] seg_lo,
	output logic dp,
	output logic wrap_led,
	output logic [7:0] leds
);
	import panel_pkg::*;

	always_ff @(posedge in_clk, posedge in_rst) begin
		if (in_rst) begin
			// reset state shows 00
			seg_hi <= seg_table[0];
			seg_lo <= seg_table[0];
			dp <= 1'b0;
			wrap_led <= 1'b0;
			leds <= '0;
		end else begin
			// nibble view, hex digits in binary mode
			seg_hi <= seg_table[cnt.count.bcd.hi];
			seg_lo <= seg_table[cnt.count.bcd.lo];
			// decimal point marks bcd mode
			dp <= cnt.bcd_mode;
			// raw byte on the leds
			leds <= cnt.count.raw;

			// sticky wrap, dropped on any clear
			if (cnt.cleared) begin
				wrap_led <= 1'b0;
			end else if (cnt.wrapped) begin
				wrap_led <= 1'b1;
			end
		end
	end

endmodule

// ==== design/panel_top.sv ====
`timescale 1ns/1ps

module panel_top (
	input logic in_clk,
	input logic in_rst,
	input logic btn_up,
	input logic btn_down,
	input logic btn_clear,
	input logic btn_mode,
	output logic [6:0] seg_hi,
	output logic [6:0] seg_lo,
	output logic dp,
	output logic wrap_led,
	output logic [panel_pkg::cnt_width - 1 : 0] leds
);
	import panel_pkg::*;

	// debounced pulses into decode
	logic up_pulse;
	logic down_pulse;
	logic clear_pulse;
	// mode toggle straight into execute
	logic mode_level;
	t_cmd cmd;

	count_if cnt_bus();

	// one debouncer per button
	debounce_button u_deb_up (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.raw(btn_up),
		.pulse(up_pulse),
		.toggled()
	);

	debounce_button u_deb_down (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.raw(btn_down),
		.pulse(down_pulse),
		.toggled()
	);

	debounce_button u_deb_clear (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.raw(btn_clear),
		.pulse(clear_pulse),
		.toggled()
	);

	// only the toggle matters for mode
	debounce_button u_deb_mode (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.raw(btn_mode),
		.pulse(),
		.toggled(mode_level)
	);

	btn_decode u_decode (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.up_pulse(up_pulse),
		.down_pulse(down_pulse),
		.clear_pulse(clear_pulse),
		.cmd(cmd)
	);

	count_exec u_exec (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.cmd(cmd),
		.mode_level(mode_level),
		.cnt(cnt_bus.exec_mp)
	);

	seg_result u_result (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.cnt(cnt_bus.res_mp),
		.seg_hi(seg_hi),
		.seg_lo(seg_lo),
		.dp(dp),
		.wrap_led(wrap_led),
		.leds(leds)
	);

endmodule

// ==== verif/panel_asserts.sv ====
`timescale 1ns/1ps

module panel_asserts (
	input logic in_clk,
	input logic in_rst,
	input logic [6:0] seg_hi,
	input logic [6:0] seg_lo,
	input logic dp,
	input logic wrap_led,
	input logic [panel_pkg::cnt_width - 1 : 0] leds
);
	import panel_pkg::*;

	// both digits follow the nibbles on the leds
	digits_match: assert property (
		@(posedge in_clk) disable iff (in_rst)
		(seg_hi == seg_table[leds[7:4]]) && (seg_lo == seg_table[leds[3:0]])
	) else $error("segment patterns do not match the led nibbles");

	// wrap led held off in reset
	wrap_off_in_reset: assert property (
		@(posedge in_clk)
		in_rst |-> !wrap_led
	) else $error("wrap led is on while reset is asserted");

	// a mode change always lands on a cleared count
	dp_change_clears: assert property (
		@(posedge in_clk) disable iff (in_rst)
		(dp != $past(dp)) |-> (leds == '0)
	) else $error("decimal point changed while the count was not zero");

	// bcd mode stays within 00..99
	bcd_in_range: assert property (
		@(posedge in_clk) disable iff (in_rst)
		dp |-> (leds <= bcd_max)
	) else $error("count is above 99 in bcd mode");

endmodule

// ==== verif/panel_tb.sv ====
`timescale 1ns/1ps

module panel_tb;
	import panel_pkg::*;

	// press length, high and low phases each
	localparam int press_cycles = stable_ticks + 3;
	localparam int wait_limit = 50;
	localparam int glitch_watch = 20;

	// button select codes
	localparam int sel_up = 0;
	localparam int sel_down = 1;
	localparam int sel_clear = 2;
	localparam int sel_mode = 3;

	logic in_clk;
	logic in_rst;
	logic btn_up;
	logic btn_down;
	logic btn_clear;
	logic btn_mode;
	logic [6:0] seg_hi;
	logic [6:0] seg_lo;
	logic dp;
	logic wrap_led;
	logic [7:0] leds;

	// reference model
	logic [7:0] ref_count;
	logic ref_bcd;
	logic ref_wrap;
	logic [31:0] rng_state;
	int error_count;

	panel_top uut (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.btn_up(btn_up),
		.btn_down(btn_down),
		.btn_clear(btn_clear),
		.btn_mode(btn_mode),
		.seg_hi(seg_hi),
		.seg_lo(seg_lo),
		.dp(dp),
		.wrap_led(wrap_led),
		.leds(leds)
	);

	bind panel_top panel_asserts u_asserts (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.seg_hi(seg_hi),
		.seg_lo(seg_lo),
		.dp(dp),
		.wrap_led(wrap_led),
		.leds(leds)
	);

	// 20 ns period
	always #10 in_clk = ~in_clk;

	// inputs change 1 ns past the edge
	task automatic next_cycle();
		@(posedge in_clk);
		#1;
	endtask

	task automatic abort_run();
		error_count++;
		$display("Done: errors found");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic report_mismatch(input string test, input logic [7:0] expected,
			input logic [7:0] actual);
		$display("Error: %s expected %0h actual %0h", test, expected, actual);
		abort_run();
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// decimal view of a bcd byte
	function automatic int bcd_to_int(input logic [7:0] b);
		return int'(b[7:4]) * 10 + int'(b[3:0]);
	endfunction

	function automatic logic [7:0] int_to_bcd(input int v);
		logic [3:0] tens;
		logic [3:0] ones;
		tens = 4'(v / 10);
		ones = 4'(v % 10);
		return {tens, ones};
	endfunction

	task automatic set_button(input int which, input logic level);
		case (which)
			sel_up: btn_up = level;
			sel_down: btn_down = level;
			sel_clear: btn_clear = level;
			default: btn_mode = level;
		endcase
	endtask

	// full press, long enough for both debounce phases
	task automatic press_button(input int which);
		set_button(which, 1'b1);
		repeat (press_cycles) next_cycle();
		set_button(which, 1'b0);
		repeat (press_cycles) next_cycle();
	endtask

	// expected effect of one command
	task automatic model_step(input int which);
		int v;
		case (which)
			sel_up: begin
				if (ref_bcd) begin
					v = bcd_to_int(ref_count);
					if (v == 99) begin
						v = 0;
						ref_wrap = 1'b1;
					end else begin
						v = v + 1;
					end
					ref_count = int_to_bcd(v);
				end else begin
					if (ref_count == 8'hff) begin
						ref_wrap = 1'b1;
					end
					ref_count = ref_count + 8'd1;
				end
			end
			sel_down: begin
				if (ref_bcd) begin
					v = bcd_to_int(ref_count);
					if (v == 0) begin
						v = 99;
						ref_wrap = 1'b1;
					end else begin
						v = v - 1;
					end
					ref_count = int_to_bcd(v);
				end else begin
					if (ref_count == 8'h00) begin
						ref_wrap = 1'b1;
					end
					ref_count = ref_count - 8'd1;
				end
			end
			sel_clear: begin
				ref_count = 8'h00;
				ref_wrap = 1'b0;
			end
			default: begin
				// mode flip clears too
				ref_bcd = ~ref_bcd;
				ref_count = 8'h00;
				ref_wrap = 1'b0;
			end
		endcase
	endtask

	// leds and dp settle a few cycles after the release
	task automatic wait_for_outputs(input string test);
		int cycles;
		cycles = 0;
		while ((leds !== ref_count || dp !== ref_bcd) && cycles < wait_limit) begin
			next_cycle();
			cycles++;
		end
		if (leds !== ref_count || dp !== ref_bcd) begin
			$display("Timeout in %s: outputs did not reach the expected count in %0d cycles",
				test, wait_limit);
			abort_run();
		end
	endtask

	task automatic check_outputs(input string test);
		assert (leds == ref_count) else report_mismatch(test, ref_count, leds);
		assert (dp == ref_bcd) else report_mismatch(test, 8'(ref_bcd), 8'(dp));
		assert (wrap_led == ref_wrap) else report_mismatch(test, 8'(ref_wrap), 8'(wrap_led));
		assert (seg_hi == seg_table[ref_count[7:4]])
			else report_mismatch(test, 8'(seg_table[ref_count[7:4]]), 8'(seg_hi));
		assert (seg_lo == seg_table[ref_count[3:0]])
			else report_mismatch(test, 8'(seg_table[ref_count[3:0]]), 8'(seg_lo));
	endtask

	task automatic run_press(input int which, input string test);
		press_button(which);
		model_step(which);
		wait_for_outputs(test);
		check_outputs(test);
	endtask

	// short high pulse, too brief to count as a press
	task automatic run_glitch(input string test);
		logic [7:0] leds_before;
		leds_before = leds;
		btn_up = 1'b1;
		repeat (stable_ticks) next_cycle();
		btn_up = 1'b0;
		repeat (glitch_watch) begin
			next_cycle();
			assert (leds == leds_before) else report_mismatch(test, leds_before, leds);
		end
	endtask

	initial begin
		int n_up;
		int steps;
		in_clk = 1'b0;
		in_rst = 1'b1;
		btn_up = 1'b0;
		btn_down = 1'b0;
		btn_clear = 1'b0;
		btn_mode = 1'b0;
		error_count = 0;
		ref_count = 8'h00;
		ref_bcd = 1'b0;
		ref_wrap = 1'b0;
		rng_state = 32'd41304;

		repeat (3) @(posedge in_clk);
		#1;
		in_rst = 1'b0;
		next_cycle();
		check_outputs("reset");

		run_glitch("glitch");

		// binary up, down through zero, clear
		repeat (3) run_press(sel_up, "binary up");
		assert (leds == 8'h03) else report_mismatch("binary up", 8'h03, leds);
		repeat (4) run_press(sel_down, "binary down");
		assert (leds == 8'hff) else report_mismatch("binary wrap", 8'hff, leds);
		run_press(sel_clear, "binary clear");

		// into bcd, random count of ups
		run_press(sel_mode, "bcd enter");
		rng_state = xorshift32(rng_state);
		n_up = 8 + int'(rng_state % 5);
		repeat (n_up) run_press(sel_up, "bcd up");
		assert (leds == int_to_bcd(n_up))
			else report_mismatch("bcd carry", int_to_bcd(n_up), leds);

		// past 99 and back under 00
		steps = 100 - n_up;
		repeat (steps) run_press(sel_up, "bcd wrap up");
		assert (leds == 8'h00) else report_mismatch("bcd wrap up", 8'h00, leds);
		run_press(sel_down, "bcd wrap down");
		assert (leds == 8'h99) else report_mismatch("bcd wrap down", 8'h99, leds);

		// back to binary
		run_press(sel_mode, "binary return");
		run_press(sel_up, "binary after mode");
		assert (leds == 8'h01) else report_mismatch("binary after mode", 8'h01, leds);

		if (error_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

// ==== sources.f ====
design/panel_pkg.sv
design/count_if.sv
design/debounce_button.sv
design/btn_decode.sv
design/count_exec.sv
design/seg_result.sv
design/panel_top.sv
verif/panel_asserts.sv
verif/panel_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= panel_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
